//--- tests/dptx_tests.txt
# M som eom dat | W cycles | V vs hs de r g b | S skip to marked word | E lane0 lane1 lane2
# All values hex; symbol bits are disp_ctl 10, disp_val 9, k 8, data 7:0
S
M 1 0 0010
M 0 1 0003
W 8
M 1 0 0011
M 0 1 0001
E 64a 64a 64a
E 24a 24a 24a
E 24a 24a 24a
W 10
S
M 1 0 0011
M 0 1 0002
E 7bc 7bc 7bc
E 2cb 2cb 2cb
E 24a 24a 24a
E 24a 24a 24a
E 3bc 3bc 3bc
E 2cb 2cb 2cb
E 24a 24a 24a
E 24a 24a 24a
E 3bc 3bc 3bc
E 2cb 2cb 2cb
E 24a 24a 24a
E 24a 24a 24a
W 10
S
M 1 0 0011
M 0 1 0000
W 8
E 611 622 633
E 244 255 266
E 3bc 3bc 3bc
E 3bc 3bc 3bc
E 200 200 200
E 2a1 2b2 2c3
V 0 0 1 11 22 33
V 0 0 1 44 55 66
V 0 1 0 00 00 00
V 1 0 0 00 00 00
V 0 0 0 aa bb cc
V 0 0 1 a1 b2 c3
W 20
E 201 211 221
E 202 212 222
E 203 213 223
E 204 214 224
E 205 215 225
E 206 216 226
E 207 217 227
E 208 218 228
E 209 219 229
E 20a 21a 22a
E 20b 21b 22b
E 20c 21c 22c
V 0 0 1 01 11 21
V 0 0 1 02 12 22
V 0 0 1 03 13 23
V 0 0 1 04 14 24
V 0 0 1 05 15 25
V 0 0 1 06 16 26
V 0 0 1 07 17 27
V 0 0 1 08 18 28
V 0 0 1 09 19 29
V 0 0 1 0a 1a 2a
V 0 0 1 0b 1b 2b
V 0 0 1 0c 1c 2c
W 20
M 0 1 0003
M 1 0 0055
M 0 1 0001
W 8
E 25a 26b 27c
E 200 200 200
V 0 0 1 5a 6b 7c
V 0 0 0 00 00 00
W 10

//--- all.f
verilog/dptx_pkg.sv
verilog/dptx_fifo.sv
verilog/dptx_msg_ctl.sv
verilog/dptx_lnk_fmt.sv
verilog/dptx_top.sv
tests/dptx_asserts.sv
tests/tb_dptx.sv

//--- run.sh
#!/bin/sh
# Build and run the DP TX testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dptx -f all.f -o sim_dptx

./obj_dir/sim_dptx > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

//--- tests/tb_dptx.sv
// ==========================================================================
// DP TX testbench
// Reads commands from the test data file, drives messages and video,
// applies random lnk_rdy back-pressure and checks every link word
// ==========================================================================

module tb_dptx;

    import dptx_pkg::*;

    localparam int tmo = 1000;                      // Cycles per wait
    localparam int ww  = lnk_lanes*lnk_sym_w;       // One output word

    logic               sys_clk;
    logic               rst_n;
    logic               msg_vld;
    logic               msg_rdy;
    logic               msg_som;
    logic               msg_eom;
    logic [msg_dat_w-1:0] msg_dat;
    logic               vid_vld;
    logic               vid_rdy;
    logic               vid_vs;
    logic               vid_hs;
    logic               vid_de;
    logic [bpc-1:0]     vid_r;
    logic [bpc-1:0]     vid_g;
    logic [bpc-1:0]     vid_b;
    logic               lnk_vld;
    logic               lnk_rdy;
    logic [ww-1:0]      lnk_dat;

    logic [ww:0]        exp_q [$];                  // Top bit set means skip to marked word
    logic [ww:0]        exp_w;                      // Entry taken from the queue
    int unsigned        seed_val;

    dptx_top dut0 (.*);

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;

    // About one cycle in four stalled
    initial
    begin
        seed_val = $urandom(80);
        forever
        begin
            @(posedge sys_clk);
            #1;
            lnk_rdy = ($urandom % 4) != 0;
        end
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_sym(input string name, input lnk_sym_t got, input lnk_sym_t exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_rdy(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_word(input logic [ww-1:0] w);
        for (int l = 0; l < lnk_lanes; l++)
            check_sym($sformatf("lnk_dat lane %0d", l),
                      lnk_sym_t'(lnk_dat[l*lnk_sym_w +: lnk_sym_w]),
                      lnk_sym_t'(w[l*lnk_sym_w +: lnk_sym_w]));
    endtask

    // Caller sits just after a rising edge and leaves the same way
    task automatic send_msg(input logic som, input logic eom, input logic [msg_dat_w-1:0] dat);
        int k;
        msg_som = som;
        msg_eom = eom;
        msg_dat = dat;
        msg_vld = 1'b1;
        k = 0;
        @(posedge sys_clk);
        while (!msg_rdy && k < tmo)
        begin
            @(posedge sys_clk);
            k++;
        end
        if (!msg_rdy)
            stop_run("Timed out waiting for msg_rdy");
        else
        begin
            #1;
            msg_vld = 1'b0;
        end
    endtask

    task automatic send_vid(input logic [31:0] vs, input logic [31:0] hs, input logic [31:0] de,
                            input logic [31:0] r, input logic [31:0] g, input logic [31:0] b);
        int k;
        vid_vs  = vs[0];
        vid_hs  = hs[0];
        vid_de  = de[0];
        vid_r   = r[bpc-1:0];
        vid_g   = g[bpc-1:0];
        vid_b   = b[bpc-1:0];
        vid_vld = 1'b1;
        k = 0;
        @(posedge sys_clk);
        while (!vid_rdy && k < tmo)
        begin
            @(posedge sys_clk);
            k++;
        end
        if (!vid_rdy)
            stop_run("Timed out waiting for vid_rdy");
        else
        begin
            #1;
            vid_vld = 1'b0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge sys_clk);
        #1;
    endtask

    // Output monitor sampling values before the edge updates them
    always @(posedge sys_clk)
    begin
        if (rst_n && lnk_vld && lnk_rdy && exp_q.size() != 0)
        begin
            if (!exp_q[0][ww])
            begin
                exp_w = exp_q.pop_front();
                compare_word(exp_w[ww-1:0]);
            end
            else if (lnk_dat[lnk_sym_w-1])                  // Lane 0 disp_ctl
            begin
                void'(exp_q.pop_front());
                if (exp_q.size() == 0)
                    stop_run("Marked link word arrived with no expected word queued");
                else
                begin
                    exp_w = exp_q.pop_front();
                    compare_word(exp_w[ww-1:0]);
                end
            end
        end
    end

    initial
    begin
        int fd;
        int k;
        string line;
        byte c;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        rst_n   = 1'b0;
        lnk_rdy = 1'b0;
        msg_vld = 1'b0;
        msg_som = 1'b0;
        msg_eom = 1'b0;
        msg_dat = '0;
        vid_vld = 1'b0;
        vid_vs  = 1'b0;
        vid_hs  = 1'b0;
        vid_de  = 1'b0;
        vid_r   = '0;
        vid_g   = '0;
        vid_b   = '0;
        repeat (8) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;

        // Link disabled so nothing goes in or comes out
        repeat (20)
        begin
            @(posedge sys_clk);
            check_rdy("lnk_vld", lnk_vld, 1'b0);
            check_rdy("vid_rdy", vid_rdy, 1'b0);
            check_rdy("msg_rdy", msg_rdy, 1'b1);
        end
        #1;

        fd = $fopen("tests/dptx_tests.txt", "r");
        if (fd == 0)
            stop_run("Could not open the test data file");
        while (!$feof(fd))
        begin
            line = "";
            c = 0;
            k = $fgets(line, fd);
            k = $sscanf(line, "%c %h %h %h %h %h %h", c, f0, f1, f2, f3, f4, f5);
            case (c)
                "M": send_msg(f0[0], f1[0], f2[msg_dat_w-1:0]);
                "W": idle(f0);
                "V": send_vid(f0, f1, f2, f3, f4, f5);
                "S": exp_q.push_back({1'b1, {ww{1'b0}}});
                "E": exp_q.push_back({1'b0, f2[10:0], f1[10:0], f0[10:0]});
                default: ;                                  // Comment or blank
            endcase
        end
        $fclose(fd);

        k = 0;
        while (exp_q.size() != 0 && k < tmo)
        begin
            @(posedge sys_clk);
            k++;
        end
        if (exp_q.size() != 0)
            stop_run("Timed out waiting for the remaining link words");
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- tests/dptx_asserts.sv
// ==========================================================================
// DP TX handshake assertions
// Bound to the transmit top level, checks valid/ready hold rules
// and a silent link output while the link is disabled
// ==========================================================================

module dptx_asserts
(
    input  logic                                sys_clk,
    input  logic                                rst_n,
    input  logic                                msg_vld,
    input  logic                                msg_rdy,
    input  logic [dptx_pkg::msg_dat_w+1:0]      msg_word,   // som, eom, dat
    input  logic                                vid_vld,
    input  logic                                vid_rdy,
    input  logic [3*dptx_pkg::bpc+2:0]          vid_beat,   // vs, hs, de, r, g, b
    input  logic                                lnk_vld,
    input  logic                                lnk_rdy,
    input  logic [dptx_pkg::lnk_lanes*dptx_pkg::lnk_sym_w-1:0] lnk_dat,
    input  logic                                lnk_en
);

    // Stalled message word holds
    a_msg_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        msg_vld && !msg_rdy |=> msg_vld && $stable(msg_word))
        else $error("Message valid dropped or word changed while stalled");

    // Stalled video beat holds
    a_vid_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        vid_vld && !vid_rdy |=> vid_vld && $stable(vid_beat))
        else $error("Video valid dropped or beat changed while stalled");

    // Output word holds under back-pressure
    a_lnk_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        lnk_en && lnk_vld && !lnk_rdy |=> lnk_vld && $stable(lnk_dat))
        else $error("Link valid dropped or symbols changed while stalled");

    a_lnk_off: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !lnk_en |-> !lnk_vld)
        else $error("Link valid high while the link is disabled");

endmodule

bind dptx_top dptx_asserts asserts0
(
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .msg_vld    (msg_vld),
    .msg_rdy    (msg_rdy),
    .msg_word   ({msg_som, msg_eom, msg_dat}),
    .vid_vld    (vid_vld),
    .vid_rdy    (vid_rdy),
    .vid_beat   ({vid_vs, vid_hs, vid_de, vid_r, vid_g, vid_b}),
    .lnk_vld    (lnk_vld),
    .lnk_rdy    (lnk_rdy),
    .lnk_dat    (lnk_dat),
    .lnk_en     (lnk_en)
);

//--- verilog/dptx_top.sv
// ==========================================================================
// DP TX top
// Single clock transmit link with the message FIFO feeding message
// control, the video FIFO feeding the link formatter and a three-lane
// symbol output
// ==========================================================================

module dptx_top
(
    input  logic                                sys_clk,
    input  logic                                rst_n,

    // Message input
    input  logic                                msg_vld,
    output logic                                msg_rdy,
    input  logic                                msg_som,    // ID word
    input  logic                                msg_eom,    // Data word
    input  logic [dptx_pkg::msg_dat_w-1:0]      msg_dat,

    // Video input, one pixel per beat
    input  logic                                vid_vld,
    output logic                                vid_rdy,
    input  logic                                vid_vs,
    input  logic                                vid_hs,
    input  logic                                vid_de,
    input  logic [dptx_pkg::bpc-1:0]            vid_r,
    input  logic [dptx_pkg::bpc-1:0]            vid_g,
    input  logic [dptx_pkg::bpc-1:0]            vid_b,

    // Link output
    output logic                                lnk_vld,
    input  logic                                lnk_rdy,
    output logic [dptx_pkg::lnk_lanes*dptx_pkg::lnk_sym_w-1:0] lnk_dat
);

    import dptx_pkg::*;

    msg_word_t      msg_in;
    vid_beat_t      vid_in;
    logic           vf_in_vld;          // Video FIFO write side
    logic           vf_in_rdy;
    logic           m_vld;
    logic           m_rdy;
    msg_word_t      m_word;
    logic           v_vld;
    logic           v_rdy;
    vid_beat_t      v_beat;
    logic           lnk_en;             // Control registers to formatter
    logic           disp_start;
    tps_t           tps;
    logic           mode_chg;

    assign msg_in = '{som: msg_som, eom: msg_eom, dat: msg_dat};
    assign vid_in = '{vs: vid_vs, hs: vid_hs, de: vid_de, r: vid_r, g: vid_g, b: vid_b};

    // Video accepted only while the link is enabled
    assign vf_in_vld = vid_vld && lnk_en;
    assign vid_rdy   = vf_in_rdy && lnk_en;

    dptx_fifo #(.depth(fifo_depth_msg), .payload_t(msg_word_t)) msg_fifo0
    (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .in_vld     (msg_vld),
        .in_rdy     (msg_rdy),
        .in_data    (msg_in),
        .out_vld    (m_vld),
        .out_rdy    (m_rdy),
        .out_data   (m_word)
    );

    dptx_fifo #(.depth(fifo_depth_vid), .payload_t(vid_beat_t)) vid_fifo0
    (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .in_vld     (vf_in_vld),
        .in_rdy     (vf_in_rdy),
        .in_data    (vid_in),
        .out_vld    (v_vld),
        .out_rdy    (v_rdy),
        .out_data   (v_beat)
    );

    dptx_msg_ctl msg_ctl0
    (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .m_vld      (m_vld),
        .m_rdy      (m_rdy),
        .m_word     (m_word),
        .lnk_en     (lnk_en),
        .disp_start (disp_start),
        .tps        (tps),
        .mode_chg   (mode_chg)
    );

    dptx_lnk_fmt lnk_fmt0
    (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .lnk_en     (lnk_en),
        .disp_start (disp_start),
        .tps        (tps),
        .mode_chg   (mode_chg),
        .v_vld      (v_vld),
        .v_rdy      (v_rdy),
        .v_beat     (v_beat),
        .lnk_vld    (lnk_vld),
        .lnk_rdy    (lnk_rdy),
        .lnk_dat    (lnk_dat)
    );

endmodule

//--- verilog/dptx_lnk_fmt.sv
// ==========================================================================
// DP TX link formatter
// Builds three lane symbols per cycle from training patterns TPS1/TPS2
// or from one video beat, one colour component per lane.
// Single output register, loaded when empty or being drained
// ==========================================================================

module dptx_lnk_fmt
(
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    lnk_en,
    input  logic                    disp_start,
    input  dptx_pkg::tps_t          tps,
    input  logic                    mode_chg,
    input  logic                    v_vld,
    output logic                    v_rdy,
    input  dptx_pkg::vid_beat_t     v_beat,
    output logic                    lnk_vld,
    input  logic                    lnk_rdy,
    output logic [dptx_pkg::lnk_lanes*dptx_pkg::lnk_sym_w-1:0] lnk_dat
);

    import dptx_pkg::*;

    logic               trn;                // Training pattern active
    logic               free;               // Output register can take a word
    logic               load;
    logic               mark;               // disp_ctl for the word being built
    logic               first_f;            // Mode changed, marked word still due
    logic [1:0]         phase;              // TPS2 position
    logic [1:0]         phase_eff;
    logic               out_vld;
    lnk_sym_t           out_sym [lnk_lanes];
    lnk_sym_t           nxt_sym [lnk_lanes];
    logic [bpc-1:0]     comp [lnk_lanes];

    assign comp[0] = v_beat.r;              // Lane 0 red
    assign comp[1] = v_beat.g;
    assign comp[2] = v_beat.b;              // Lane 2 blue

    assign trn       = (tps == tps1) || (tps == tps2);
    assign free      = !out_vld || lnk_rdy;
    assign v_rdy     = lnk_en && !trn && free;          // No video during training
    assign load      = lnk_en && free && (trn || v_vld);
    assign mark      = mode_chg || first_f;
    assign phase_eff = mode_chg ? 2'd0 : phase;         // Restart at K28.5
    assign lnk_vld   = out_vld && lnk_en;               // Silent while disabled

    // Next word, priority tps1, tps2, video
    always_comb
    begin
        for (int i = 0; i < lnk_lanes; i++)
        begin
            nxt_sym[i].disp_ctl = mark;
            nxt_sym[i].disp_val = disp_start;
            nxt_sym[i].k        = 1'b0;
            nxt_sym[i].dat      = '0;                   // Plain blanking
            if (tps == tps1)
                nxt_sym[i].dat = sym_d10_2;
            else if (tps == tps2)
            begin
                case (phase_eff)
                    2'd0:
                    begin
                        nxt_sym[i].k   = 1'b1;
                        nxt_sym[i].dat = sym_k28_5;
                    end
                    2'd1:    nxt_sym[i].dat = sym_d11_6;
                    default: nxt_sym[i].dat = sym_d10_2;
                endcase
            end
            else if (v_beat.de)
                nxt_sym[i].dat = comp[i];               // Active pixel
            else if (v_beat.hs || v_beat.vs)
            begin
                nxt_sym[i].k   = 1'b1;                  // Sync blanking
                nxt_sym[i].dat = sym_k28_5;
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (load)
            out_sym <= nxt_sym;
    end

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_vld <= 1'b0;
            first_f <= 1'b0;
            phase   <= 2'd0;
        end
        else
        begin
            if (!lnk_en)
                out_vld <= 1'b0;            // Flush on disable
            else if (load)
                out_vld <= 1'b1;
            else if (lnk_rdy)
                out_vld <= 1'b0;

            // Cleared once the marked word is loaded
            if (load)
                first_f <= 1'b0;
            else if (mode_chg)
                first_f <= 1'b1;

            if (load && (tps == tps2))
                phase <= phase_eff + 2'd1;  // Wraps after D10.2, D10.2
            else if (mode_chg)
                phase <= 2'd0;
        end
    end

    // Lane 0 in the low bits
    generate
        for (genvar l = 0; l < lnk_lanes; l++)
        begin : gen_lane
            assign lnk_dat[l*lnk_sym_w +: lnk_sym_w] = out_sym[l];
        end
    endgenerate

endmodule

//--- verilog/dptx_msg_ctl.sv
// ==========================================================================
// DP TX message control
// Decodes som/eom word pairs from the message FIFO into the link
// enable, start disparity and training pattern registers.
// Pulses mode_chg when the link enable or the pattern changes
// ==========================================================================

module dptx_msg_ctl
(
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    m_vld,
    output logic                    m_rdy,
    input  dptx_pkg::msg_word_t     m_word,
    output logic                    lnk_en,
    output logic                    disp_start,
    output dptx_pkg::tps_t          tps,
    output logic                    mode_chg
);

    import dptx_pkg::*;

    logic                   take;           // Word consumed this cycle
    logic                   pend_vld;       // ID waiting for its data word
    logic [msg_dat_w-1:0]   pend_id;
    tps_t                   tps_new;

    assign take    = m_vld && m_rdy;
    assign tps_new = tps_t'(m_word.dat[1:0]);

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_rdy      <= 1'b0;
            pend_vld   <= 1'b0;
            pend_id    <= '0;
            lnk_en     <= 1'b0;
            disp_start <= 1'b0;
            tps        <= tps_none;
            mode_chg   <= 1'b0;
        end
        else
        begin
            m_rdy    <= 1'b1;               // Always accepts once out of reset
            mode_chg <= 1'b0;               // Single cycle pulse

            if (take && m_word.som)
            begin
                pend_id  <= m_word.dat;
                pend_vld <= !m_word.eom;    // One-word message has no data, dropped
            end
            else if (take && m_word.eom)
            begin
                pend_vld <= 1'b0;
                if (pend_vld && (pend_id == msg_id_ctl))
                begin
                    lnk_en     <= m_word.dat[0];
                    disp_start <= m_word.dat[1];
                    mode_chg   <= (m_word.dat[0] != lnk_en);    // Only a real change
                end
                else if (pend_vld && (pend_id == msg_id_tps))
                begin
                    tps      <= tps_new;
                    mode_chg <= (tps_new != tps);
                end
                // Unknown ID or eom without som falls through
            end
        end
    end

endmodule

//--- verilog/dptx_fifo.sv
// ==========================================================================
// DP TX FIFO
// Synchronous valid/ready FIFO with a type parameter for its payload.
// Circular buffer followed by a prefetch output register, so a word
// shows at the output one cycle after the edge that wrote it
// ==========================================================================

module dptx_fifo
#(
    parameter int  depth     = 4,           // Total words held, output register included
    parameter type payload_t = logic [7:0]
)
(
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        in_vld,
    output logic        in_rdy,
    input  payload_t    in_data,
    output logic        out_vld,
    input  logic        out_rdy,
    output payload_t    out_data
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [aw:0] depth_c = (aw + 1)'(depth);

    payload_t           mem [depth];        // Buffer, no reset
    logic [aw-1:0]      wr_ptr;
    logic [aw-1:0]      rd_ptr;
    logic [aw:0]        count;              // Words in mem
    logic [aw:0]        occ;                // Words in mem and output register
    logic               wr;
    logic               load;               // Move head of mem into output register

    // Pointer wrap for any depth
    function automatic logic [aw-1:0] ptr_inc(input logic [aw-1:0] p);
        ptr_inc = (p == aw'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign occ    = count + {{aw{1'b0}}, out_vld};
    assign in_rdy = (occ < depth_c);                    // Low when full
    assign wr     = in_vld && in_rdy;
    assign load   = (count != '0) && (!out_vld || out_rdy);

    always_ff @(posedge sys_clk)
    begin
        if (wr)
            mem[wr_ptr] <= in_data;
        if (load)
            out_data <= mem[rd_ptr];                    // Payload register
    end

    always_ff @(posedge sys_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_vld <= 1'b0;
        end
        else
        begin
            if (wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (load)
                rd_ptr <= ptr_inc(rd_ptr);

            case ({wr, load})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle, or write and load together
            endcase

            if (load)
                out_vld <= 1'b1;
            else if (out_rdy)
                out_vld <= 1'b0;                    // Drained, nothing behind it
        end
    end

endmodule

//--- verilog/dptx_pkg.sv
// ==========================================================================
// DP TX link package
// Link, message and symbol constants shared by the transmit blocks,
// plus the payload types carried by the FIFOs and the lane symbols
// ==========================================================================

package dptx_pkg;

    // Link
    localparam int lnk_lanes = 3;           // One colour component per lane
    localparam int lnk_sym_w = 11;          // disp_ctl + disp_val + k + 8 data bits

    // Video
    localparam int bpc = 8;                 // Bits per component

    // Message
    localparam int msg_dat_w = 16;          // Message word width
    localparam logic [msg_dat_w-1:0] msg_id_ctl = 16'h0010;    // Control
    localparam logic [msg_dat_w-1:0] msg_id_tps = 16'h0011;    // Training pattern select

    // Symbol values
    localparam logic [bpc-1:0] sym_d10_2 = 8'h4a;      // TPS1, data
    localparam logic [bpc-1:0] sym_k28_5 = 8'hbc;      // Comma, blanking start
    localparam logic [bpc-1:0] sym_d11_6 = 8'hcb;      // TPS2 second symbol

    // FIFO depths
    localparam int fifo_depth_msg = 4;
    localparam int fifo_depth_vid = 8;

    // Training pattern select
    typedef enum logic [1:0]
    {
        tps_none = 2'd0,
        tps1     = 2'd1,
        tps2     = 2'd2
    } tps_t;

    // Message FIFO word
    typedef struct packed
    {
        logic                   som;        // Start of message, carries ID
        logic                   eom;        // End of message, carries data
        logic [msg_dat_w-1:0]   dat;
    } msg_word_t;

    // Video FIFO beat, one pixel
    typedef struct packed
    {
        logic                   vs;
        logic                   hs;
        logic                   de;
        logic [bpc-1:0]         r;
        logic [bpc-1:0]         g;
        logic [bpc-1:0]         b;
    } vid_beat_t;

    // One lane symbol
    typedef struct packed
    {
        logic                   disp_ctl;   // Disparity control, first symbol of a mode
        logic                   disp_val;   // Start disparity
        logic                   k;          // Control character
        logic [bpc-1:0]         dat;
    } lnk_sym_t;

endpackage
